//--- src.f
+incdir+.
pktbuf_pkg.sv
free_id_list.sv
input_comp.sv
pkt_buffer.sv
pkt_release.sv
pkt_store_top.sv
tb_pkt_store.sv

//--- tb_pkt_store.sv
`include "pktbuf_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_store;

    import pktbuf_pkg::*;

    localparam int NROWS = 15;

    logic                      clk;
    logic                      rst;
    logic                      eth_sop;
    logic                      eth_eop;
    logic [`ETH_DWIDTH-1:0]    eth_data;
    logic [`ETH_EWIDTH-1:0]    eth_empty;
    logic                      eth_valid;
    logic                      pkt_sop;
    logic                      pkt_eop;
    logic                      pkt_valid;
    logic [`ETH_DWIDTH-1:0]    pkt_data;
    logic [`ETH_EWIDTH-1:0]    pkt_empty;
    logic                      meta_valid;
    metadata_t                 meta_data;
    logic                      release_valid;
    logic [`PKT_AWIDTH-1:0]    release_id;
    logic [`PKT_SLOT_BITS-1:0] release_flits;
    logic                      release_busy;
    logic                      out_sop;
    logic                      out_eop;
    logic                      out_valid;
    logic [`ETH_DWIDTH-1:0]    out_data;
    logic [`ETH_EWIDTH-1:0]    out_empty;

    // packet length, empty of the last flit, release after store, release oldest first
    // a release value of 2 also pulses release_valid while busy
    int row_len   [NROWS] = '{1, 31, 4, 2, 7, 3, 16, 5, 31, 2, 1, 6, 1, 3, 12};
    int row_empty [NROWS] = '{5, 0, 17, 63, 0, 9, 1, 2, 0, 3, 4, 7, 8, 10, 11};
    int row_rel   [NROWS] = '{1, 2, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 2};
    int row_first [NROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1};

    // reference model state
    logic [`ETH_DWIDTH-1:0] exp_data  [`NUM_PKTS][32];
    logic [`ETH_EWIDTH-1:0] exp_empty [`NUM_PKTS][32];
    int                     stored_len [`NUM_PKTS];
    int                     free_q [$];
    int                     held_q [$];
    int                     exp_meta_q [$];
    int                     meta_count = 0;
    logic                   in_release = 1'b0;
    logic                   strobe_due = 1'b0;
    logic [15:0]            lfsr = 16'd36340;
    int                     errors = 0;
    int                     checks = 0;

    pkt_store_top uut (
        .clk           (clk),
        .rst           (rst),
        .eth_sop       (eth_sop),
        .eth_eop       (eth_eop),
        .eth_data      (eth_data),
        .eth_empty     (eth_empty),
        .eth_valid     (eth_valid),
        .pkt_sop       (pkt_sop),
        .pkt_eop       (pkt_eop),
        .pkt_valid     (pkt_valid),
        .pkt_data      (pkt_data),
        .pkt_empty     (pkt_empty),
        .meta_valid    (meta_valid),
        .meta_data     (meta_data),
        .release_valid (release_valid),
        .release_id    (release_id),
        .release_flits (release_flits),
        .release_busy  (release_busy),
        .out_sop       (out_sop),
        .out_eop       (out_eop),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_empty     (out_empty)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [`ETH_DWIDTH-1:0] got,
                             input logic [`ETH_DWIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return b;
    endfunction

    function automatic logic [`ETH_DWIDTH-1:0] rand_word();
        logic [`ETH_DWIDTH-1:0] w;
        for (int b = 0; b < `ETH_DWIDTH; b++) begin
            w[b] = rand_bit();
        end
        return w;
    endfunction

    // header and metadata strobes and stray output flits
    always @(negedge clk) begin
        int id;
        if (!rst) begin
            // strobes come only in the cycle after a stored eop flit
            check_val("meta_valid", meta_valid, strobe_due);
            check_val("pkt_valid", pkt_valid, strobe_due);
            check_val("pkt_sop", pkt_sop, strobe_due);
            check_val("pkt_eop", pkt_eop, strobe_due);
            strobe_due = 1'b0;
            if (out_valid && !in_release) begin
                errors++;
                $display("out_valid went high at %0t with no release in progress", $time);
            end
            if (meta_valid) begin
                if (exp_meta_q.size() == 0) begin
                    errors++;
                    $display("meta_valid at %0t but no stored packet was expected", $time);
                end else begin
                    id = exp_meta_q.pop_front();
                    check_val("meta_data.pkt_id", meta_data.pkt_id, id);
                    check_val("meta_data.flits", meta_data.flits, stored_len[id]);
                    check_val("pkt_empty", pkt_empty, 0);
                    check_val("pkt_data", pkt_data, exp_data[id][0]);
                    meta_count++;
                end
            end
        end
    end

    task automatic send_pkt(input int len, input int empty, output logic stored);
        int id;
        int target;
        int waited;
        logic [`ETH_DWIDTH-1:0] word;
        stored = (free_q.size() > 0);
        id = 0;
        target = meta_count + 1;
        if (stored) begin
            id = free_q.pop_front();
            stored_len[id] = len;
            exp_meta_q.push_back(id);
        end
        for (int i = 0; i < len; i++) begin
            word = rand_word();
            @(posedge clk);
            #1;
            eth_valid = 1'b1;
            eth_sop   = (i == 0);
            eth_eop   = (i == len - 1);
            eth_data  = word;
            eth_empty = (i == len - 1) ? empty[`ETH_EWIDTH-1:0] : '0;
            if (stored) begin
                exp_data[id][i]  = word;
                exp_empty[id][i] = eth_empty;
            end
        end
        @(posedge clk);
        #1;
        eth_valid = 1'b0;
        eth_sop   = 1'b0;
        eth_eop   = 1'b0;
        strobe_due = stored;
        if (stored) begin
            waited = 0;
            while (meta_count < target && waited < 40) begin
                @(posedge clk);
                waited++;
            end
            if (meta_count < target) begin
                errors++;
                $display("timeout waiting for meta_valid of packet id %0d", id);
            end
            held_q.push_back(id);
            // let the last write land
            repeat (2) @(negedge clk);
        end else begin
            // monitor flags any strobe of a dropped packet
            repeat (20) @(negedge clk);
        end
    endtask

    task automatic release_pkt(input int id, input int len, input logic pulse);
        int waited;
        waited = 0;
        while (release_busy && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (release_busy) begin
            errors++;
            $display("timeout waiting for release_busy to drop before id %0d", id);
        end
        @(posedge clk);
        #1;
        release_valid = 1'b1;
        release_id    = id[`PKT_AWIDTH-1:0];
        release_flits = len[`PKT_SLOT_BITS-1:0];
        in_release    = 1'b1;
        @(posedge clk);
        #1;
        release_valid = 1'b0;
        waited = 1;
        @(negedge clk);
        while (!out_valid && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            errors++;
            $display("timeout waiting for out_valid after release of id %0d", id);
        end else begin
            check_val("first out_valid latency", waited, 2);
            for (int i = 0; i < len; i++) begin
                if (i > 0) begin
                    @(negedge clk);
                end
                check_val("out_valid", out_valid, 1'b1);
                check_val("out_sop", out_sop, i == 0);
                check_val("out_eop", out_eop, i == len - 1);
                check_val("out_data", out_data, exp_data[id][i]);
                check_val("out_empty", out_empty, exp_empty[id][i]);
                if (pulse && i == 0) begin
                    check_val("release_busy", release_busy, 1'b1);
                    @(posedge clk);
                    #1;
                    release_valid = 1'b1;
                    release_id    = id[`PKT_AWIDTH-1:0] + 1'b1;
                    release_flits = 5;
                end else if (pulse && i == 1) begin
                    @(posedge clk);
                    #1;
                    release_valid = 1'b0;
                end
            end
        end
        repeat (4) begin
            @(negedge clk);
            check_val("out_valid", out_valid, 1'b0);
        end
        in_release = 1'b0;
        free_q.push_back(id);
    endtask

    initial begin
        int id;
        logic stored;
        rst           = 1'b1;
        eth_sop       = 1'b0;
        eth_eop       = 1'b0;
        eth_data      = '0;
        eth_empty     = '0;
        eth_valid     = 1'b0;
        release_valid = 1'b0;
        release_id    = '0;
        release_flits = '0;
        for (int i = 0; i < `NUM_PKTS; i++) begin
            free_q.push_back(i);
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_val("meta_valid", meta_valid, 1'b0);
        check_val("out_valid", out_valid, 1'b0);
        check_val("release_busy", release_busy, 1'b0);

        for (int r = 0; r < NROWS; r++) begin
            if (row_first[r] != 0) begin
                id = held_q.pop_front();
                release_pkt(id, stored_len[id], 1'b0);
            end
            send_pkt(row_len[r], row_empty[r], stored);
            if (stored && row_rel[r] != 0) begin
                id = held_q.pop_back();
                release_pkt(id, row_len[r], row_rel[r] == 2);
            end
        end
        while (held_q.size() > 0) begin
            id = held_q.pop_front();
            release_pkt(id, stored_len[id], 1'b0);
        end

        repeat (5) @(negedge clk);
        if (exp_meta_q.size() != 0) begin
            errors++;
            $display("%0d stored packets never produced meta_valid", exp_meta_q.size());
        end
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pkt_store_top.sv
`include "pktbuf_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module pkt_store_top (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      eth_sop,
    input  logic                      eth_eop,
    input  logic [`ETH_DWIDTH-1:0]    eth_data,
    input  logic [`ETH_EWIDTH-1:0]    eth_empty,
    input  logic                      eth_valid,

    output logic                      pkt_sop,
    output logic                      pkt_eop,
    output logic                      pkt_valid,
    output logic [`ETH_DWIDTH-1:0]    pkt_data,
    output logic [`ETH_EWIDTH-1:0]    pkt_empty,

    output logic                      meta_valid,
    output pktbuf_pkg::metadata_t     meta_data,

    input  logic                      release_valid,
    input  logic [`PKT_AWIDTH-1:0]    release_id,
    input  logic [`PKT_SLOT_BITS-1:0] release_flits,
    output logic                      release_busy,

    output logic                      out_sop,
    output logic                      out_eop,
    output logic                      out_valid,
    output logic [`ETH_DWIDTH-1:0]    out_data,
    output logic [`ETH_EWIDTH-1:0]    out_empty
);

    import pktbuf_pkg::*;

    logic [`PKT_AWIDTH-1:0]    free_id;
    logic                      free_valid;
    logic                      alloc;
    logic                      free_push;
    logic [`PKT_AWIDTH-1:0]    free_push_id;

    logic                      wr_en;
    logic [`PKTBUF_AWIDTH-1:0] wr_addr;
    flit_t                     wr_data;
    logic                      rd_en;
    logic [`PKTBUF_AWIDTH-1:0] rd_addr;
    flit_t                     rd_data;

    free_id_list u_free_list (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .free_id      (free_id),
        .free_valid   (free_valid),
        .free_push    (free_push),
        .free_push_id (free_push_id)
    );

    input_comp u_input (
        .clk                  (clk),
        .rst                  (rst),
        .eth_sop              (eth_sop),
        .eth_eop              (eth_eop),
        .eth_data             (eth_data),
        .eth_empty            (eth_empty),
        .eth_valid            (eth_valid),
        .pkt_buffer_address   (wr_addr),
        .pkt_buffer_write     (wr_en),
        .pkt_buffer_writedata (wr_data),
        .emptylist_out_data   (free_id),
        .emptylist_out_valid  (free_valid),
        .emptylist_out_ready  (alloc),
        .pkt_sop              (pkt_sop),
        .pkt_eop              (pkt_eop),
        .pkt_valid            (pkt_valid),
        .pkt_data             (pkt_data),
        .pkt_empty            (pkt_empty),
        .meta_valid           (meta_valid),
        .meta_data            (meta_data)
    );

    pkt_buffer u_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    pkt_release u_release (
        .clk           (clk),
        .rst           (rst),
        .release_valid (release_valid),
        .release_id    (release_id),
        .release_flits (release_flits),
        .release_busy  (release_busy),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .out_sop       (out_sop),
        .out_eop       (out_eop),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_empty     (out_empty),
        .free_push     (free_push),
        .free_push_id  (free_push_id)
    );

endmodule

`default_nettype wire

//--- pkt_release.sv
`include "pktbuf_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module pkt_release (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      release_valid,
    input  logic [`PKT_AWIDTH-1:0]    release_id,
    input  logic [`PKT_SLOT_BITS-1:0] release_flits,
    output logic                      release_busy,

    output logic                      rd_en,
    output logic [`PKTBUF_AWIDTH-1:0] rd_addr,
    input  pktbuf_pkg::flit_t         rd_data,

    output logic                      out_sop,
    output logic                      out_eop,
    output logic                      out_valid,
    output logic [`ETH_DWIDTH-1:0]    out_data,
    output logic [`ETH_EWIDTH-1:0]    out_empty,

    output logic                      free_push,
    output logic [`PKT_AWIDTH-1:0]    free_push_id
);

    logic                      start;
    logic                      valid_d;
    logic [`PKT_SLOT_BITS-1:0] remaining;
    logic [`PKT_AWIDTH-1:0]    cur_id;

    // commands during a release are ignored
    assign start = release_valid & ~release_busy;

    // control path
    always_ff @(posedge clk) begin
        if (rst) begin
            release_busy <= 1'b0;
            rd_en        <= 1'b0;
            valid_d      <= 1'b0;
            free_push    <= 1'b0;
        end else begin
            // rd_data shows up one cycle after the read
            valid_d   <= rd_en;
            free_push <= 1'b0;
            if (free_push) begin
                release_busy <= 1'b0;
            end
            if (start) begin
                release_busy <= 1'b1;
                rd_en        <= (release_flits != '0);
                // empty release just returns the id
                free_push    <= (release_flits == '0);
            end else if (rd_en && remaining == `PKT_SLOT_BITS'(1)) begin
                // last read issued, push lines up with the last flit out
                rd_en     <= 1'b0;
                free_push <= 1'b1;
            end
        end
    end

    // address walk and flit count
    always_ff @(posedge clk) begin
        if (start) begin
            rd_addr   <= {release_id, {`PKT_SLOT_BITS{1'b0}}};
            remaining <= release_flits;
            cur_id    <= release_id;
        end else if (rd_en) begin
            rd_addr   <= rd_addr + 1'b1;
            remaining <= remaining - 1'b1;
        end
    end

    assign free_push_id = cur_id;

    // decode stored flit onto the stream
    assign out_valid = valid_d;
    assign out_sop   = valid_d & rd_data.f.sop;
    assign out_eop   = valid_d & rd_data.f.eop;
    assign out_data  = rd_data.f.data;
    assign out_empty = rd_data.f.empty;

endmodule

`default_nettype wire

//--- pkt_buffer.sv
`include "pktbuf_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module pkt_buffer (
    input  logic                      clk,

    input  logic                      wr_en,
    input  logic [`PKTBUF_AWIDTH-1:0] wr_addr,
    input  pktbuf_pkg::flit_t         wr_data,

    input  logic                      rd_en,
    input  logic [`PKTBUF_AWIDTH-1:0] rd_addr,
    output pktbuf_pkg::flit_t         rd_data
);

    localparam int DEPTH = 1 << `PKTBUF_AWIDTH;

    // 8 slots of 32 flits
    logic [`FLIT_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data.raw;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data.raw <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- input_comp.sv
`include "pktbuf_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module input_comp (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      eth_sop,
    input  logic                      eth_eop,
    input  logic [`ETH_DWIDTH-1:0]    eth_data,
    input  logic [`ETH_EWIDTH-1:0]    eth_empty,
    input  logic                      eth_valid,

    output logic [`PKTBUF_AWIDTH-1:0] pkt_buffer_address,
    output logic                      pkt_buffer_write,
    output pktbuf_pkg::flit_t         pkt_buffer_writedata,

    input  logic [`PKT_AWIDTH-1:0]    emptylist_out_data,
    input  logic                      emptylist_out_valid,
    output logic                      emptylist_out_ready,

    output logic                      pkt_sop,
    output logic                      pkt_eop,
    output logic                      pkt_valid,
    output logic [`ETH_DWIDTH-1:0]    pkt_data,
    output logic [`ETH_EWIDTH-1:0]    pkt_empty,

    output logic                      meta_valid,
    output pktbuf_pkg::metadata_t     meta_data
);

    import pktbuf_pkg::*;

    logic                      accept;
    logic [`PKTBUF_AWIDTH-1:0] addr_r;
    logic                      write_r;
    flit_t                     wdata_r;
    logic [`PKT_AWIDTH-1:0]    current_id;
    logic [`PKT_SLOT_BITS-1:0] flit_cnt;
    logic [`PKT_SLOT_BITS-1:0] cur_count;

    // flits are dropped while no id is free
    assign accept = eth_valid & emptylist_out_valid;

    assign emptylist_out_ready = eth_valid & eth_sop;

    // header goes out as a one-flit packet
    assign pkt_empty = '0;

    // count including the flit on the bus now
    assign cur_count = eth_sop ? `PKT_SLOT_BITS'(1) : flit_cnt + 1'b1;

    // stage one control
    always_ff @(posedge clk) begin
        if (rst) begin
            write_r <= 1'b0;
        end else begin
            write_r <= accept;
        end
    end

    // stage one address and data
    always_ff @(posedge clk) begin
        if (accept) begin
            wdata_r.f.sop   <= eth_sop;
            wdata_r.f.eop   <= eth_eop;
            wdata_r.f.empty <= eth_empty;
            wdata_r.f.data  <= eth_data;
            if (eth_sop) begin
                // slot base is id * 32
                addr_r     <= {emptylist_out_data, {`PKT_SLOT_BITS{1'b0}}};
                current_id <= emptylist_out_data;
            end else begin
                addr_r <= addr_r + 1'b1;
            end
        end
    end

    // stage two, lands in memory one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_buffer_write <= 1'b0;
        end else begin
            pkt_buffer_write <= write_r;
        end
    end

    always_ff @(posedge clk) begin
        pkt_buffer_address   <= addr_r;
        pkt_buffer_writedata <= wdata_r;
    end

    // header and metadata strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_valid  <= 1'b0;
            pkt_sop    <= 1'b0;
            pkt_eop    <= 1'b0;
            meta_valid <= 1'b0;
            flit_cnt   <= '0;
        end else begin
            pkt_valid  <= accept & eth_eop;
            pkt_sop    <= accept & eth_eop;
            pkt_eop    <= accept & eth_eop;
            meta_valid <= accept & eth_eop;
            if (accept) begin
                flit_cnt <= eth_eop ? '0 : cur_count;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept & eth_eop) begin
            // single-flit packet has no latched id yet
            meta_data.pkt_id <= eth_sop ? emptylist_out_data : current_id;
            meta_data.flits  <= cur_count;
        end
        // only the first flit is treated as header
        if (eth_valid & eth_sop) begin
            pkt_data <= eth_data;
        end
    end

endmodule

`default_nettype wire

//--- free_id_list.sv
`include "pktbuf_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module free_id_list (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   alloc,
    output logic [`PKT_AWIDTH-1:0] free_id,
    output logic                   free_valid,

    input  logic                   free_push,
    input  logic [`PKT_AWIDTH-1:0] free_push_id
);

    localparam int DEPTH = `NUM_PKTS;

    logic [`PKT_AWIDTH-1:0] ids [DEPTH];
    logic [`PKT_AWIDTH-1:0] head;
    logic [`PKT_AWIDTH-1:0] tail;
    logic [`PKT_AWIDTH:0]   count;
    logic                   pop;

    assign free_valid = (count != '0);
    assign free_id    = ids[head];

    // a pop needs an id on hand
    assign pop = alloc & free_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            // list starts full, so tail wraps back to slot 0
            tail  <= '0;
            count <= DEPTH[`PKT_AWIDTH:0];
        end else begin
            if (pop) begin
                head <= head + 1'b1;
            end
            if (free_push) begin
                tail <= tail + 1'b1;
            end
            case ({free_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // id storage, each slot loaded with its own index at reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                ids[i] <= i[`PKT_AWIDTH-1:0];
            end
        end else if (free_push) begin
            ids[tail] <= free_push_id;
        end
    end

endmodule

`default_nettype wire

//--- pktbuf_pkg.sv
`include "pktbuf_defines.svh"
`default_nettype none

package pktbuf_pkg;

    // decoded view of one stored flit
    typedef struct packed {
        logic                   sop;
        logic                   eop;
        logic [`ETH_EWIDTH-1:0] empty;
        logic [`ETH_DWIDTH-1:0] data;
    } flit_fields_t;

    // same word, raw as the buffer holds it
    typedef union packed {
        logic [`FLIT_WIDTH-1:0] raw;
        flit_fields_t           f;
    } flit_t;

    // handed to the parser with the header flit
    typedef struct packed {
        logic [`PKT_AWIDTH-1:0]    pkt_id;
        logic [`PKT_SLOT_BITS-1:0] flits;
    } metadata_t;

endpackage

`default_nettype wire

//--- pktbuf_defines.svh
`ifndef PKTBUF_DEFINES_SVH
`define PKTBUF_DEFINES_SVH

// ethernet stream word
`define ETH_DWIDTH 512
`define ETH_EWIDTH 6

// packet slots and flits per slot
`define PKT_AWIDTH 3
`define PKT_SLOT_BITS 5

// flit address into the packet buffer
`define PKTBUF_AWIDTH (`PKT_AWIDTH + `PKT_SLOT_BITS)

`define NUM_PKTS (1 << `PKT_AWIDTH)

// sop, eop, empty and data as stored
`define FLIT_WIDTH (`ETH_DWIDTH + `ETH_EWIDTH + 2)

`endif
